/* compile.f */
+incdir+verilog
verilog/cc_pkg.sv
verilog/spill_register.sv
verilog/mul_unit.sv
verilog/mini_core.sv
verilog/core_complex.sv
verilog/tcdm_arbiter.sv
verilog/cc_tile.sv
tests/tb_cc_tile.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_cc_tile
FILELIST  := compile.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "TB PASSED" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/tb_cc_tile.sv */
`timescale 1ns/1ps
`include "cc_defines.svh"

module tb_cc_tile;

  localparam int ProgLen        = 19;
  localparam int WatchdogCycles = 40 * ProgLen * 2;
  localparam logic [31:0] BootAddrs [2] = '{32'h0000_1000, 32'h0000_2000};

  logic                             clk_i;
  logic                             rst_i;
  logic [1:0][`CC_DATA_W-1:0]       inst_addr_o;
  logic [1:0]                       inst_valid_o;
  logic [1:0][`CC_DATA_W-1:0]       inst_data_i;
  logic [1:0]                       inst_ready_i;
  cc_pkg::dreq_t                    data_q_o;
  logic                             data_qvalid_o;
  logic                             data_qready_i;
  cc_pkg::dresp_t                   data_p_i;
  logic                             data_pvalid_i;
  logic                             data_pready_o;
  cc_pkg::core_events_t [1:0]       core_events_o;
  logic [1:0]                       halted_o;

  logic [31:0] prog [2][ProgLen];
  logic [31:0] model_regs [2][`CC_NUM_REGS];
  logic [31:0] model_pc [2];
  logic [31:0] model_mem [logic [31:0]];
  logic [31:0] dmem [logic [31:0]];
  logic [63:0] exp_store_q [2][$];
  logic [31:0] resp_data_q [$];
  int          resp_due_q [$];
  logic [31:0] rng_state = 32'hde1f;
  int          cycle = 0;
  int          retired_cnt [2] = '{0, 0};
  bit          halt_seen [2] = '{1'b0, 1'b0};
  bit          reset_checked = 1'b0;
  // Strobe counts per core, in the order load, store, offload
  int          event_cnt [2][3];
  int          exp_event_cnt [2][3];
  string       event_names [3] = '{"load", "store", "offload"};

  cc_tile cc_tile_inst (.*);

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic report_failure(string what);
    $display("[ERROR] %s", what);
    $display("TB FAILED");
    $fatal(1);
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] encode_imm(cc_pkg::opcode_e op, int rd, int rs1, int imm);
    return {op, 4'(rd), 4'(rs1), 4'h0, 16'(imm)};
  endfunction

  function automatic logic [31:0] encode_reg(cc_pkg::opcode_e op, int rd, int rs1, int rs2);
    return {op, 4'(rd), 4'(rs1), 4'(rs2), 16'h0};
  endfunction

  // Contents of a word never written
  function automatic logic [31:0] fill_word(logic [31:0] addr);
    return (addr * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
  endfunction

  function automatic logic [31:0] fetch_word(int c, logic [31:0] addr);
    int idx;
    idx = int'((addr - BootAddrs[c]) >> 2);
    if (addr >= BootAddrs[c] && idx < ProgLen) begin
      return prog[c][idx];
    end else begin
      return encode_imm(cc_pkg::HALT, 0, 0, 0);
    end
  endfunction

  function automatic logic [31:0] model_read(logic [31:0] addr);
    return model_mem.exists(addr) ? model_mem[addr] : fill_word(addr);
  endfunction

  task automatic load_programs();
    // Core 0 keeps its data below word 0x800
    prog[0] = '{
      encode_imm(cc_pkg::ADDI, 1, 0, 7),
      encode_imm(cc_pkg::ADDI, 2, 0, 13),
      encode_imm(cc_pkg::ADDI, 3, 0, -5),
      encode_reg(cc_pkg::MUL, 4, 1, 2),
      encode_reg(cc_pkg::MUL, 5, 2, 3),
      encode_reg(cc_pkg::MUL, 6, 1, 3),
      encode_reg(cc_pkg::MUL, 7, 4, 5),
      encode_imm(cc_pkg::SW, 4, 0, 'h10),
      encode_imm(cc_pkg::SW, 5, 0, 'h11),
      encode_imm(cc_pkg::SW, 6, 0, 'h12),
      encode_imm(cc_pkg::SW, 7, 0, 'h13),
      encode_imm(cc_pkg::LW, 8, 0, 'h10),
      encode_imm(cc_pkg::LW, 9, 0, 'h13),
      encode_imm(cc_pkg::ADDI, 10, 8, 100),
      encode_imm(cc_pkg::SW, 10, 0, 'h20),
      encode_imm(cc_pkg::SW, 9, 0, 'h21),
      encode_reg(cc_pkg::MUL, 11, 9, 8),
      encode_imm(cc_pkg::SW, 11, 0, 'h22),
      encode_imm(cc_pkg::HALT, 0, 0, 0)
    };
    // Core 1 works from a base of 0x800
    prog[1] = '{
      encode_imm(cc_pkg::ADDI, 1, 0, 'h800),
      encode_imm(cc_pkg::ADDI, 2, 0, 'h1234),
      encode_imm(cc_pkg::ADDI, 3, 0, -300),
      encode_reg(cc_pkg::MUL, 4, 2, 3),
      encode_reg(cc_pkg::MUL, 5, 3, 3),
      encode_reg(cc_pkg::MUL, 6, 2, 2),
      encode_reg(cc_pkg::MUL, 7, 6, 4),
      encode_imm(cc_pkg::SW, 4, 1, 0),
      encode_imm(cc_pkg::SW, 5, 1, 1),
      encode_imm(cc_pkg::SW, 6, 1, 2),
      encode_imm(cc_pkg::SW, 7, 1, 3),
      encode_imm(cc_pkg::LW, 8, 1, 0),
      encode_imm(cc_pkg::LW, 9, 1, 3),
      encode_imm(cc_pkg::ADDI, 10, 9, -1),
      encode_imm(cc_pkg::SW, 10, 1, 4),
      encode_imm(cc_pkg::SW, 8, 1, 5),
      encode_reg(cc_pkg::MUL, 11, 8, 10),
      encode_imm(cc_pkg::SW, 11, 1, 6),
      encode_imm(cc_pkg::HALT, 0, 0, 0)
    };
    for (int c = 0; c < 2; c++) begin
      model_pc[c] = BootAddrs[c];
      for (int r = 0; r < `CC_NUM_REGS; r++) begin
        model_regs[c][r] = '0;
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // Reference ISA model, one step per accepted fetch
  // ----------------------------------------------------------------------
  task automatic model_step(int c, logic [31:0] addr, logic [31:0] word);
    logic [3:0]  op, rd, rs1, rs2;
    logic [31:0] imm, a, ea;
    assert (addr == model_pc[c])
      else report_mismatch($sformatf("inst_addr_o[%0d]", c), addr, model_pc[c]);
    model_pc[c] = model_pc[c] + 32'd4;
    op  = word[31:28];
    rd  = word[27:24];
    rs1 = word[23:20];
    rs2 = word[19:16];
    imm = {{16{word[15]}}, word[15:0]};
    a   = model_regs[c][rs1];
    ea  = a + imm;
    case (op)
      cc_pkg::ADDI: model_regs[c][rd] = ea;
      cc_pkg::LW: begin
        model_regs[c][rd] = model_read(ea);
        exp_event_cnt[c][0]++;
      end
      cc_pkg::SW: begin
        model_mem[ea] = model_regs[c][rd];
        exp_store_q[c].push_back({ea, model_regs[c][rd]});
        exp_event_cnt[c][1]++;
      end
      cc_pkg::MUL: begin
        model_regs[c][rd] = a * model_regs[c][rs2];
        exp_event_cnt[c][2]++;
      end
      default: ;
    endcase
    model_regs[c][0] = '0;
  endtask

  // Stores are told apart by address range
  task automatic check_store(cc_pkg::dreq_t q);
    int          c;
    logic [63:0] exp;
    c = (q.addr >= 32'h0000_0800) ? 1 : 0;
    assert (exp_store_q[c].size() > 0)
      else report_failure($sformatf("store to 0x%08h reached the port with none expected", q.addr));
    exp = exp_store_q[c].pop_front();
    assert (q.addr == exp[63:32]) else report_mismatch("data_q_o.addr", q.addr, exp[63:32]);
    assert (q.data == exp[31:0]) else report_mismatch("data_q_o.data", q.data, exp[31:0]);
    assert (q.strb == 4'hf) else report_mismatch("data_q_o.strb", 32'(q.strb), 32'hf);
    dmem[q.addr] = q.data;
  endtask

  task automatic queue_read(logic [31:0] addr);
    int due;
    rng_state = xorshift32(rng_state);
    due = cycle + 1 + int'(rng_state % 3);
    // Keep responses in order
    if (resp_due_q.size() > 0 && due < resp_due_q[$]) begin
      due = resp_due_q[$];
    end
    resp_data_q.push_back(dmem.exists(addr) ? dmem[addr] : fill_word(addr));
    resp_due_q.push_back(due);
  endtask

  task automatic check_reset_state();
    assert (inst_valid_o == '0) else report_mismatch("inst_valid_o", 32'(inst_valid_o), 0);
    assert (!data_qvalid_o) else report_mismatch("data_qvalid_o", 32'(data_qvalid_o), 0);
    assert (halted_o == '0) else report_mismatch("halted_o", 32'(halted_o), 0);
    assert (core_events_o == '0)
      else report_mismatch("core_events_o", 32'(core_events_o), 0);
    for (int c = 0; c < 2; c++) begin
      assert (inst_addr_o[c] == BootAddrs[c])
        else report_mismatch($sformatf("inst_addr_o[%0d]", c), inst_addr_o[c], BootAddrs[c]);
    end
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    rng_state = xorshift32(rng_state);
    r = rng_state;
    for (int c = 0; c < 2; c++) begin
      inst_ready_i[c] = (r[2*c+:2] != 2'b00);
      inst_data_i[c]  = fetch_word(c, inst_addr_o[c]);
    end
    data_qready_i = (r[5:4] != 2'b00);
    if (resp_data_q.size() > 0 && resp_due_q[0] <= cycle) begin
      data_pvalid_i   = 1'b1;
      data_p_i.data   = resp_data_q[0];
      data_p_i.error  = 1'b0;
    end else begin
      data_pvalid_i = 1'b0;
      data_p_i      = '0;
    end
  endtask

  // ----------------------------------------------------------------------
  // Clock, reset and stimulus
  // ----------------------------------------------------------------------
  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    rst_i         = 1'b1;
    inst_ready_i  = '0;
    inst_data_i   = '0;
    data_qready_i = 1'b0;
    data_p_i      = '0;
    data_pvalid_i = 1'b0;
    load_programs();
    repeat (3) @(posedge clk_i);
    #1 rst_i = 1'b0;
    forever begin
      @(posedge clk_i);
      #1 drive_inputs();
    end
  end

  // Bookkeeping on each sampled edge
  always @(posedge clk_i) begin
    if (!rst_i) begin
      cycle++;
      if (!reset_checked) begin
        check_reset_state();
        reset_checked = 1'b1;
      end
      for (int c = 0; c < 2; c++) begin
        if (inst_valid_o[c] && inst_ready_i[c]) begin
          model_step(c, inst_addr_o[c], inst_data_i[c]);
        end
        if (halted_o[c] && !halt_seen[c]) begin
          assert (retired_cnt[c] == ProgLen)
            else report_mismatch($sformatf("core_events_o[%0d].retired count", c),
                                 32'(retired_cnt[c]), 32'(ProgLen));
          halt_seen[c] = 1'b1;
        end
        if (core_events_o[c].retired) begin
          retired_cnt[c]++;
        end
        event_cnt[c][0] += int'(core_events_o[c].load);
        event_cnt[c][1] += int'(core_events_o[c].store);
        event_cnt[c][2] += int'(core_events_o[c].offload);
      end
      if (data_qvalid_o && data_qready_i) begin
        if (data_q_o.write) begin
          check_store(data_q_o);
        end else begin
          queue_read(data_q_o.addr);
        end
      end
      if (data_pvalid_i && data_pready_o) begin
        void'(resp_data_q.pop_front());
        void'(resp_due_q.pop_front());
      end
    end
  end

  halt0_sticky: assert property (@(posedge clk_i) disable iff (rst_i)
    halted_o[0] |=> halted_o[0])
    else report_failure("halted_o[0] dropped after the core halted");

  halt1_sticky: assert property (@(posedge clk_i) disable iff (rst_i)
    halted_o[1] |=> halted_o[1])
    else report_failure("halted_o[1] dropped after the core halted");

  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    report_failure("watchdog expired before both cores halted");
  end

  initial begin
    wait (rst_i == 1'b0);
    wait (&halted_o);
    repeat (8) @(posedge clk_i);
    for (int c = 0; c < 2; c++) begin
      assert (exp_store_q[c].size() == 0)
        else report_failure($sformatf("core %0d lost %0d stores", c, exp_store_q[c].size()));
      assert (retired_cnt[c] == ProgLen)
        else report_mismatch($sformatf("core_events_o[%0d].retired count", c),
                             32'(retired_cnt[c]), 32'(ProgLen));
      for (int e = 0; e < 3; e++) begin
        assert (event_cnt[c][e] == exp_event_cnt[c][e])
          else report_mismatch($sformatf("core_events_o[%0d].%s count", c, event_names[e]),
                               32'(event_cnt[c][e]), 32'(exp_event_cnt[c][e]));
      end
    end
    assert (resp_data_q.size() == 0)
      else report_failure("read responses were left undelivered");
    $display("TB PASSED");
    $finish;
  end

endmodule

/* verilog/cc_tile.sv */
`timescale 1ns/1ps
`include "cc_defines.svh"

module cc_tile (
  input  logic                             clk_i,
  input  logic                             rst_i,
  // Instruction ports, one per core
  output logic [1:0][`CC_DATA_W-1:0]       inst_addr_o,
  output logic [1:0]                       inst_valid_o,
  input  logic [1:0][`CC_DATA_W-1:0]       inst_data_i,
  input  logic [1:0]                       inst_ready_i,
  // Shared data memory port
  output cc_pkg::dreq_t                    data_q_o,
  output logic                             data_qvalid_o,
  input  logic                             data_qready_i,
  input  cc_pkg::dresp_t                   data_p_i,
  input  logic                             data_pvalid_i,
  output logic                             data_pready_o,
  output cc_pkg::core_events_t [1:0]       core_events_o,
  output logic [1:0]                       halted_o
);

  localparam logic [1:0][`CC_DATA_W-1:0] BootAddrs = {32'h0000_2000, 32'h0000_1000};

  cc_pkg::dreq_t [1:0]  cc_req;
  cc_pkg::dresp_t [1:0] cc_resp;
  logic [1:0]           cc_req_valid, cc_req_ready, cc_resp_valid, cc_resp_ready;

  for (genvar i = 0; i < 2; i++) begin : gen_cc
    core_complex #(
      .BootAddr ( BootAddrs[i] )
    ) i_core_complex (
      .clk_i,
      .rst_i,
      .inst_addr_o   ( inst_addr_o[i]   ),
      .inst_data_i   ( inst_data_i[i]   ),
      .inst_valid_o  ( inst_valid_o[i]  ),
      .inst_ready_i  ( inst_ready_i[i]  ),
      .data_q_o      ( cc_req[i]        ),
      .data_qvalid_o ( cc_req_valid[i]  ),
      .data_qready_i ( cc_req_ready[i]  ),
      .data_p_i      ( cc_resp[i]       ),
      .data_pvalid_i ( cc_resp_valid[i] ),
      .data_pready_o ( cc_resp_ready[i] ),
      .core_events_o ( core_events_o[i] ),
      .halted_o      ( halted_o[i]      )
    );
  end

  tcdm_arbiter i_tcdm_arbiter (
    .clk_i,
    .rst_i,
    .req_i        ( cc_req        ),
    .req_valid_i  ( cc_req_valid  ),
    .req_ready_o  ( cc_req_ready  ),
    .resp_o       ( cc_resp       ),
    .resp_valid_o ( cc_resp_valid ),
    .resp_ready_i ( cc_resp_ready ),
    .q_o          ( data_q_o      ),
    .q_valid_o    ( data_qvalid_o ),
    .q_ready_i    ( data_qready_i ),
    .p_i          ( data_p_i      ),
    .p_valid_i    ( data_pvalid_i ),
    .p_ready_o    ( data_pready_o )
  );

endmodule

/* verilog/tcdm_arbiter.sv */
`timescale 1ns/1ps
`include "cc_defines.svh"

module tcdm_arbiter (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  cc_pkg::dreq_t [1:0]  req_i,
  input  logic [1:0]           req_valid_i,
  output logic [1:0]           req_ready_o,
  output cc_pkg::dresp_t [1:0] resp_o,
  output logic [1:0]           resp_valid_o,
  input  logic [1:0]           resp_ready_i,
  output cc_pkg::dreq_t        q_o,
  output logic                 q_valid_o,
  input  logic                 q_ready_i,
  input  cc_pkg::dresp_t       p_i,
  input  logic                 p_valid_i,
  output logic                 p_ready_o
);

  localparam int unsigned Depth = `CC_ARB_DEPTH;
  localparam int unsigned PtrW  = $clog2(Depth);

  logic [Depth-1:0] src_q;
  logic [PtrW-1:0]  wr_ptr_q, rd_ptr_q;
  logic [PtrW:0]    count_q;
  logic [1:0]       eligible;
  logic             full, push, pop, head;
  logic             gnt, last_q, lock_q, lock_idx_q;

  // Reads need a free routing slot, writes never wait for one
  assign full        = (count_q == (PtrW+1)'(Depth));
  assign eligible[0] = req_valid_i[0] && (req_i[0].write || !full);
  assign eligible[1] = req_valid_i[1] && (req_i[1].write || !full);

  // Stalled grant is held so the output payload stays put
  always_comb begin
    if (lock_q) begin
      gnt = lock_idx_q;
    end else if (&eligible) begin
      gnt = !last_q;
    end else begin
      gnt = eligible[1];
    end
  end

  assign q_o         = req_i[gnt];
  assign q_valid_o   = eligible[gnt];
  assign req_ready_o = q_ready_i ? (eligible & (gnt ? 2'b10 : 2'b01)) : 2'b00;

  // ----------------------------------------------------------------------
  // Read response routing
  // ----------------------------------------------------------------------
  assign push = q_valid_o && q_ready_i && !q_o.write;
  assign pop  = p_valid_i && p_ready_o;
  assign head = src_q[rd_ptr_q];

  assign resp_o          = {p_i, p_i};
  assign resp_valid_o[0] = p_valid_i && !head;
  assign resp_valid_o[1] = p_valid_i && head;
  assign p_ready_o       = resp_ready_i[head];

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      last_q     <= 1'b1;
      lock_q     <= 1'b0;
      lock_idx_q <= 1'b0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
    end else begin
      if (q_valid_o && q_ready_i) begin
        last_q <= gnt;
      end
      lock_q     <= q_valid_o && !q_ready_i;
      lock_idx_q <= gnt;
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + (PtrW+1)'(push) - (PtrW+1)'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      src_q[wr_ptr_q] <= gnt;
    end
  end

  a_resp_expected: assert property (@(posedge clk_i) disable iff (rst_i)
    p_valid_i |-> (count_q != '0))
    else $error("read response with no read outstanding");

endmodule

/* verilog/core_complex.sv */
`timescale 1ns/1ps
`include "cc_defines.svh"

module core_complex #(
  parameter logic [`CC_DATA_W-1:0] BootAddr = 32'h0000_1000,
  parameter bit RegisterOffloadReq  = 1'b1,
  parameter bit RegisterOffloadResp = 1'b1,
  parameter bit RegisterTCDMReq     = 1'b0,
  parameter bit RegisterTCDMResp    = 1'b0
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  output logic [`CC_DATA_W-1:0] inst_addr_o,
  input  logic [`CC_DATA_W-1:0] inst_data_i,
  output logic                  inst_valid_o,
  input  logic                  inst_ready_i,
  output cc_pkg::dreq_t         data_q_o,
  output logic                  data_qvalid_o,
  input  logic                  data_qready_i,
  input  cc_pkg::dresp_t        data_p_i,
  input  logic                  data_pvalid_i,
  output logic                  data_pready_o,
  output cc_pkg::core_events_t  core_events_o,
  output logic                  halted_o
);

  cc_pkg::dreq_t     core_dreq;
  cc_pkg::dresp_t    core_dresp;
  cc_pkg::acc_req_t  core_acc_req, mul_req;
  cc_pkg::acc_resp_t core_acc_resp, mul_resp;

  logic core_dreq_valid, core_dreq_ready, core_dresp_valid, core_dresp_ready;
  logic core_acc_req_valid, core_acc_req_ready, mul_req_valid, mul_req_ready;
  logic core_acc_resp_valid, core_acc_resp_ready, mul_resp_valid, mul_resp_ready;

  mini_core #(
    .BootAddr ( BootAddr )
  ) i_mini_core (
    .clk_i,
    .rst_i,
    .inst_addr_o,
    .inst_data_i,
    .inst_valid_o,
    .inst_ready_i,
    .data_q_o      ( core_dreq           ),
    .data_qvalid_o ( core_dreq_valid     ),
    .data_qready_i ( core_dreq_ready     ),
    .data_p_i      ( core_dresp          ),
    .data_pvalid_i ( core_dresp_valid    ),
    .data_pready_o ( core_dresp_ready    ),
    .acc_q_o       ( core_acc_req        ),
    .acc_qvalid_o  ( core_acc_req_valid  ),
    .acc_qready_i  ( core_acc_req_ready  ),
    .acc_p_i       ( core_acc_resp       ),
    .acc_pvalid_i  ( core_acc_resp_valid ),
    .acc_pready_o  ( core_acc_resp_ready ),
    .core_events_o,
    .halted_o
  );

  // ----------------------------------------------------------------------
  // Offload path
  // ----------------------------------------------------------------------
  spill_register #(
    .T      ( cc_pkg::acc_req_t   ),
    .Bypass ( !RegisterOffloadReq )
  ) i_spill_acc_req (
    .clk_i,
    .rst_i,
    .valid_i ( core_acc_req_valid ),
    .ready_o ( core_acc_req_ready ),
    .data_i  ( core_acc_req       ),
    .valid_o ( mul_req_valid      ),
    .ready_i ( mul_req_ready      ),
    .data_o  ( mul_req            )
  );

  mul_unit i_mul_unit (
    .clk_i,
    .rst_i,
    .req_i        ( mul_req        ),
    .req_valid_i  ( mul_req_valid  ),
    .req_ready_o  ( mul_req_ready  ),
    .resp_o       ( mul_resp       ),
    .resp_valid_o ( mul_resp_valid ),
    .resp_ready_i ( mul_resp_ready )
  );

  spill_register #(
    .T      ( cc_pkg::acc_resp_t   ),
    .Bypass ( !RegisterOffloadResp )
  ) i_spill_acc_resp (
    .clk_i,
    .rst_i,
    .valid_i ( mul_resp_valid      ),
    .ready_o ( mul_resp_ready      ),
    .data_i  ( mul_resp            ),
    .valid_o ( core_acc_resp_valid ),
    .ready_i ( core_acc_resp_ready ),
    .data_o  ( core_acc_resp       )
  );

  // ----------------------------------------------------------------------
  // Data memory path
  // ----------------------------------------------------------------------
  spill_register #(
    .T      ( cc_pkg::dreq_t   ),
    .Bypass ( !RegisterTCDMReq )
  ) i_spill_tcdm_req (
    .clk_i,
    .rst_i,
    .valid_i ( core_dreq_valid ),
    .ready_o ( core_dreq_ready ),
    .data_i  ( core_dreq       ),
    .valid_o ( data_qvalid_o   ),
    .ready_i ( data_qready_i   ),
    .data_o  ( data_q_o        )
  );

  spill_register #(
    .T      ( cc_pkg::dresp_t   ),
    .Bypass ( !RegisterTCDMResp )
  ) i_spill_tcdm_resp (
    .clk_i,
    .rst_i,
    .valid_i ( data_pvalid_i    ),
    .ready_o ( data_pready_o    ),
    .data_i  ( data_p_i         ),
    .valid_o ( core_dresp_valid ),
    .ready_i ( core_dresp_ready ),
    .data_o  ( core_dresp       )
  );

  a_dreq_known: assert property (@(posedge clk_i) disable iff (rst_i)
    data_qvalid_o |-> !$isunknown(data_q_o))
    else $error("data request holds unknown bits while valid");

endmodule

/* verilog/mini_core.sv */
`timescale 1ns/1ps
`include "cc_defines.svh"

module mini_core #(
  parameter logic [`CC_DATA_W-1:0] BootAddr = 32'h0000_1000
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // Instruction port
  output logic [`CC_DATA_W-1:0] inst_addr_o,
  input  logic [`CC_DATA_W-1:0] inst_data_i,
  output logic                  inst_valid_o,
  input  logic                  inst_ready_i,
  // Data port
  output cc_pkg::dreq_t         data_q_o,
  output logic                  data_qvalid_o,
  input  logic                  data_qready_i,
  input  cc_pkg::dresp_t        data_p_i,
  input  logic                  data_pvalid_i,
  output logic                  data_pready_o,
  // Offload port
  output cc_pkg::acc_req_t      acc_q_o,
  output logic                  acc_qvalid_o,
  input  logic                  acc_qready_i,
  input  cc_pkg::acc_resp_t     acc_p_i,
  input  logic                  acc_pvalid_i,
  output logic                  acc_pready_o,
  output cc_pkg::core_events_t  core_events_o,
  output logic                  halted_o
);

  typedef enum logic [2:0] {ST_BOOT, ST_FETCH, ST_EXEC, ST_LOAD, ST_HALT} state_e;

  state_e                  state_q, state_d;
  logic [`CC_DATA_W-1:0]   pc_q;
  cc_pkg::instr_t          instr_q;
  logic [`CC_DATA_W-1:0]   regs_q [`CC_NUM_REGS];
  logic [`CC_NUM_REGS-1:0] pending_q;
  logic [`CC_DATA_W-1:0]   rs1_val, rs2_val, rd_val, imm_sext;
  logic [`CC_DATA_W-1:0]   wb_data;
  cc_pkg::opcode_e         opcode;
  logic                    hazard, retire, wb_en;

  // ----------------------------------------------------------------------
  // Decode and operand read
  // ----------------------------------------------------------------------
  assign opcode   = instr_q.itype.opcode;
  assign imm_sext = {{(`CC_DATA_W-16){instr_q.itype.imm[15]}}, instr_q.itype.imm};

  assign rs1_val = (instr_q.itype.rs1 == '0) ? '0 : regs_q[instr_q.itype.rs1];
  assign rs2_val = (instr_q.rtype.rs2 == '0) ? '0 : regs_q[instr_q.rtype.rs2];
  assign rd_val  = (instr_q.itype.rd == '0) ? '0 : regs_q[instr_q.itype.rd];

  // Wait on any register still owed by an outstanding MUL
  assign hazard = pending_q[instr_q.itype.rs1] || pending_q[instr_q.itype.rd] ||
                  ((opcode == cc_pkg::MUL) && pending_q[instr_q.rtype.rs2]) ||
                  ((opcode == cc_pkg::HALT) && (|pending_q));

  // Data addresses count words
  assign data_q_o.addr  = rs1_val + imm_sext;
  assign data_q_o.write = (opcode == cc_pkg::SW);
  assign data_q_o.data  = (opcode == cc_pkg::SW) ? rd_val : '0;
  assign data_q_o.strb  = (opcode == cc_pkg::SW) ? 4'hf : 4'h0;

  assign acc_q_o.id = instr_q.rtype.rd;
  assign acc_q_o.a  = rs1_val;
  assign acc_q_o.b  = rs2_val;

  assign inst_addr_o   = pc_q;
  assign data_pready_o = (state_q == ST_LOAD);
  assign acc_pready_o  = 1'b1;
  assign halted_o      = (state_q == ST_HALT);

  // ----------------------------------------------------------------------
  // Control FSM
  // ----------------------------------------------------------------------
  always_comb begin
    state_d       = state_q;
    retire        = 1'b0;
    wb_en         = 1'b0;
    wb_data       = data_p_i.data;
    inst_valid_o  = 1'b0;
    data_qvalid_o = 1'b0;
    acc_qvalid_o  = 1'b0;
    core_events_o = '0;
    unique case (state_q)
      ST_BOOT: state_d = ST_FETCH;
      ST_FETCH: begin
        inst_valid_o = 1'b1;
        if (inst_ready_i) begin
          state_d = ST_EXEC;
        end
      end
      ST_EXEC: begin
        if (!hazard) begin
          case (opcode)
            cc_pkg::ADDI: begin
              wb_en   = 1'b1;
              wb_data = rs1_val + imm_sext;
              retire  = 1'b1;
            end
            cc_pkg::LW: begin
              data_qvalid_o = 1'b1;
              if (data_qready_i) begin
                state_d = ST_LOAD;
              end
            end
            cc_pkg::SW: begin
              data_qvalid_o       = 1'b1;
              retire              = data_qready_i;
              core_events_o.store = data_qready_i;
            end
            cc_pkg::MUL: begin
              acc_qvalid_o          = 1'b1;
              retire                = acc_qready_i;
              core_events_o.offload = acc_qready_i;
            end
            // HALT and unknown words retire at once
            default: retire = 1'b1;
          endcase
        end
        if (retire) begin
          state_d = (opcode == cc_pkg::HALT) ? ST_HALT : ST_FETCH;
        end
      end
      ST_LOAD: begin
        if (data_pvalid_i) begin
          wb_en              = 1'b1;
          retire             = 1'b1;
          core_events_o.load = 1'b1;
          state_d            = ST_FETCH;
        end
      end
      ST_HALT: state_d = ST_HALT;
      default: state_d = ST_BOOT;
    endcase
    core_events_o.retired = retire;
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q   <= ST_BOOT;
      pc_q      <= BootAddr;
      pending_q <= '0;
    end else begin
      state_q <= state_d;
      if (retire) begin
        pc_q <= pc_q + `CC_DATA_W'(4);
      end
      if (acc_qvalid_o && acc_qready_i) begin
        pending_q[instr_q.rtype.rd] <= 1'b1;
      end
      if (acc_pvalid_i) begin
        pending_q[acc_p_i.id] <= 1'b0;
      end
    end
  end

  // Two write ports, never to the same register in one cycle
  always_ff @(posedge clk_i) begin
    if (inst_valid_o && inst_ready_i) begin
      instr_q <= cc_pkg::instr_t'(inst_data_i);
    end
    if (wb_en) begin
      regs_q[instr_q.itype.rd] <= wb_data;
    end
    if (acc_pvalid_i) begin
      regs_q[acc_p_i.id] <= acc_p_i.data;
    end
  end

  a_resp_pending: assert property (@(posedge clk_i) disable iff (rst_i)
    acc_pvalid_i |-> pending_q[acc_p_i.id])
    else $error("MUL result for register with no pending bit");

  // pc steps by one word only as the FSM leaves execute or load
  a_pc_on_retire: assert property (@(posedge clk_i) disable iff (rst_i)
    !$stable(pc_q) |-> (pc_q == $past(pc_q) + `CC_DATA_W'(4)) &&
                       ($past(state_q) inside {ST_EXEC, ST_LOAD}) &&
                       (state_q inside {ST_FETCH, ST_HALT}))
    else $error("pc moved without a completed instruction");

endmodule

/* verilog/mul_unit.sv */
`timescale 1ns/1ps
`include "cc_defines.svh"

module mul_unit (
  input  logic              clk_i,
  input  logic              rst_i,
  input  cc_pkg::acc_req_t  req_i,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  output cc_pkg::acc_resp_t resp_o,
  output logic              resp_valid_o,
  input  logic              resp_ready_i
);

  localparam int unsigned Stages = `CC_MUL_LATENCY;

  logic [Stages-1:0] valid_q;
  cc_pkg::acc_resp_t stage_q [Stages];
  logic              stall;

  // Whole pipe freezes while the last product waits
  assign stall       = valid_q[Stages-1] && !resp_ready_i;
  assign req_ready_o = !stall;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      valid_q <= '0;
    end else if (!stall) begin
      valid_q[0] <= req_valid_i;
      for (int unsigned i = 1; i < Stages; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall) begin
      stage_q[0].id    <= req_i.id;
      // Low word of the product only
      stage_q[0].data  <= req_i.a * req_i.b;
      stage_q[0].error <= 1'b0;
      for (int unsigned i = 1; i < Stages; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign resp_o       = stage_q[Stages-1];
  assign resp_valid_o = valid_q[Stages-1];

endmodule

/* verilog/spill_register.sv */
`timescale 1ns/1ps

module spill_register #(
  parameter type T      = logic,
  parameter bit  Bypass = 1'b0
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  if (Bypass) begin : gen_bypass
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : gen_spill
    T     a_data_q, b_data_q;
    logic a_full_q, b_full_q;
    logic a_fill, a_drain, b_fill, b_drain;

    // Slot a takes new data, slot b catches it when the output stalls
    assign a_fill  = valid_i && ready_o;
    assign a_drain = a_full_q && !b_full_q;
    assign b_fill  = a_drain && !ready_i;
    assign b_drain = b_full_q && ready_i;

    always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        a_full_q <= a_fill || (a_full_q && !a_drain);
        b_full_q <= b_fill || (b_full_q && !b_drain);
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_fill) begin
        a_data_q <= data_i;
      end
      if (b_fill) begin
        b_data_q <= a_data_q;
      end
    end

    assign valid_o = a_full_q || b_full_q;
    assign ready_o = !a_full_q || !b_full_q;
    // Older item sits in b
    assign data_o  = b_full_q ? b_data_q : a_data_q;

    a_hold_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      valid_o && !ready_i |=> $stable(data_o))
      else $error("spill register output changed while stalled");
  end

endmodule

/* verilog/cc_pkg.sv */
`include "cc_defines.svh"

package cc_pkg;

  typedef logic [3:0] reg_idx_t;

  typedef enum logic [3:0] {
    ADDI = 4'h1,
    LW   = 4'h2,
    SW   = 4'h3,
    MUL  = 4'h4,
    HALT = 4'hf
  } opcode_e;

  // ----------------------------------------------------------------------
  // Instruction word
  // ----------------------------------------------------------------------
  // ADDI, LW and SW use the immediate form. SW stores register rd.
  typedef struct packed {
    opcode_e     opcode;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    logic [3:0]  unused;
    logic [15:0] imm;
  } instr_itype_t;

  // MUL uses the register form
  typedef struct packed {
    opcode_e     opcode;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [15:0] unused;
  } instr_rtype_t;

  typedef union packed {
    instr_itype_t itype;
    instr_rtype_t rtype;
  } instr_t;

  // ----------------------------------------------------------------------
  // Port payloads
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [`CC_DATA_W-1:0] addr;
    logic                  write;
    logic [`CC_DATA_W-1:0] data;
    logic [3:0]            strb;
  } dreq_t;

  typedef struct packed {
    logic [`CC_DATA_W-1:0] data;
    logic                  error;
  } dresp_t;

  typedef struct packed {
    reg_idx_t              id;
    logic [`CC_DATA_W-1:0] a;
    logic [`CC_DATA_W-1:0] b;
  } acc_req_t;

  typedef struct packed {
    reg_idx_t              id;
    logic [`CC_DATA_W-1:0] data;
    logic                  error;
  } acc_resp_t;

  typedef struct packed {
    logic retired;
    logic load;
    logic store;
    logic offload;
  } core_events_t;

endpackage

/* verilog/cc_defines.svh */
`ifndef CC_DEFINES_SVH
`define CC_DEFINES_SVH

// Data and address width, one word
`define CC_DATA_W 32

// Architectural registers, register 0 reads zero
`define CC_NUM_REGS 16

// Multiplier pipeline stages
`define CC_MUL_LATENCY 3

// Read routing queue in the arbiter, a power of two
`define CC_ARB_DEPTH 4

`endif
